// File: design/ifu_pkg.sv
// shared fetch types; 64-bit addresses, 128-bit read lines of four 32-bit words, no RVC

package ifu_pkg;

  // ==========================================================================
  // widths
  // ==========================================================================
  localparam int unsigned ADDR_W = 64;
  localparam int unsigned LINE_W = 128;
  localparam int unsigned INST_W = 32;
  localparam int unsigned RESP_W = 2;

  // four instructions per line, word index taken from pc[3:2]
  localparam int unsigned WORD_IDX_LSB = 2;
  localparam int unsigned WORD_IDX_W   = 2;

  // ==========================================================================
  // types
  // ==========================================================================
  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [LINE_W-1:0] line_t;
  typedef logic [INST_W-1:0] inst_t;
  typedef logic [RESP_W-1:0] resp_t;

  // read channel sequencing
  typedef enum logic {
    IDLE,
    WAIT_DATA
  } bus_state_e;

  // ==========================================================================
  // constants
  // ==========================================================================
  localparam addr_t RESET_PC = 64'h0000_0000_8000_0000;

  // pc step per committed instruction
  localparam int unsigned INST_BYTES = 4;

  // AXI read response OKAY
  localparam resp_t RESP_OKAY = 2'b00;

endpackage

// File: design/ifu_pc_reg.sv
// program counter; rst_n high resets to RESET_PC, jump targets must be 4-byte aligned
`timescale 1ns/1ns

module ifu_pc_reg (
  input  logic           clk,
  input  logic           rst_n,
  input  logic           jump_i,
  input  ifu_pkg::addr_t jump_target_i,
  input  logic           stall_i,
  input  logic           rd_done_i,
  input  logic           discard_i,
  output ifu_pkg::addr_t pc_o
);

  ifu_pkg::addr_t pc_q;
  logic           redirect;
  logic           advance;

  // a stalled pipeline ignores the redirect
  assign redirect = jump_i && !stall_i;

  // beat taken for the current pc
  // a discarded beat belongs to the old path and must not move the pc
  assign advance = rd_done_i && !discard_i;

  // ==========================================================================
  // pc register
  // ==========================================================================
  always_ff @(posedge clk) begin
    if (rst_n) begin
      pc_q <= ifu_pkg::RESET_PC;
    end else if (redirect) begin
      pc_q <= jump_target_i;
    end else if (advance) begin
      pc_q <= pc_q + ifu_pkg::addr_t'(ifu_pkg::INST_BYTES);
    end else begin
      pc_q <= pc_q;
    end
  end

  assign pc_o = pc_q;

  // ==========================================================================
  // checks
  // ==========================================================================

  // no compressed instructions, so every fetch address is word aligned
  // (covers targets coming in from the later stages too)
  a_pc_aligned : assert property (
    @(posedge clk) disable iff (rst_n)
    pc_q[1:0] == 2'b00
  ) else $error("pc not aligned to four bytes");

endmodule

// File: design/ifu_bus_fsm.sv
// single outstanding AXI-style read, no IDs or bursts; stall only back-pressures the R channel
`timescale 1ns/1ns

module ifu_bus_fsm (
  input  logic clk,
  input  logic rst_n,
  input  logic arready_i,
  input  logic rvalid_i,
  input  logic stall_i,
  input  logic jump_i,
  output logic arvalid_o,
  output logic rready_o,
  output logic rd_done_o,
  output logic discard_o
);

  ifu_pkg::bus_state_e state_q;
  ifu_pkg::bus_state_e state_d;

  logic arvalid_q;
  logic rready_q;
  logic discard_q;
  logic ar_fire;
  logic rd_done;

  // ==========================================================================
  // handshakes
  // ==========================================================================

  // address accepted
  assign ar_fire = arvalid_q && arready_i;

  // data beat accepted
  assign rd_done = rready_q && rvalid_i && !stall_i;

  // ==========================================================================
  // state machine
  // ==========================================================================
  always_comb begin
    state_d = state_q;
    case (state_q)
      ifu_pkg::IDLE: begin
        if (ar_fire) begin
          state_d = ifu_pkg::WAIT_DATA;
        end
      end
      ifu_pkg::WAIT_DATA: begin
        if (rd_done) begin
          state_d = ifu_pkg::IDLE;
        end
      end
      default: begin
        state_d = ifu_pkg::IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst_n) begin
      state_q <= ifu_pkg::IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // registered channel strobes
  // arvalid one cycle after the beat, rready one cycle after the address
  always_ff @(posedge clk) begin
    if (rst_n) begin
      arvalid_q <= 1'b0;
      rready_q  <= 1'b0;
    end else begin
      arvalid_q <= (state_d == ifu_pkg::IDLE);
      rready_q  <= (state_d == ifu_pkg::WAIT_DATA);
    end
  end

  // ==========================================================================
  // discard flag
  // ==========================================================================

  // redirect while the read is out, so the returning line is stale
  always_ff @(posedge clk) begin
    if (rst_n) begin
      discard_q <= 1'b0;
    end else if (rd_done) begin
      discard_q <= 1'b0;
    end else if (state_q == ifu_pkg::WAIT_DATA && jump_i && !stall_i) begin
      discard_q <= 1'b1;
    end
  end

  // ==========================================================================
  // outputs
  // ==========================================================================
  assign arvalid_o = arvalid_q;
  assign rready_o  = stall_i ? 1'b0 : rready_q;
  assign rd_done_o = rd_done;
  assign discard_o = discard_q;

  // ==========================================================================
  // checks
  // ==========================================================================

  // an offered address stays up until the slave takes it
  a_ar_held : assert property (
    @(posedge clk) disable iff (rst_n)
    arvalid_o && !arready_i |=> arvalid_o
  ) else $error("arvalid dropped before the address was accepted");

  // the stale flag only lives while a read is out
  a_discard_waiting : assert property (
    @(posedge clk) disable iff (rst_n)
    discard_q |-> state_q == ifu_pkg::WAIT_DATA
  ) else $error("discard set outside WAIT_DATA");

endmodule

// File: design/ifu_word_out.sv
// purely combinational; pc must point at the line being returned, fault is valid only with commit
`timescale 1ns/1ns

module ifu_word_out (
  input  ifu_pkg::addr_t pc_i,
  input  logic           jump_i,
  input  ifu_pkg::addr_t jump_target_i,
  input  logic           stall_i,
  input  logic           rd_done_i,
  input  logic           discard_i,
  input  ifu_pkg::line_t rdata_i,
  input  ifu_pkg::resp_t rresp_i,
  output ifu_pkg::addr_t inst_addr_o,
  output ifu_pkg::inst_t inst_o,
  output logic           commit_o,
  output logic           fault_o
);

  logic                               redirect;
  logic [ifu_pkg::WORD_IDX_W-1:0]     word_idx;
  logic                               commit;

  assign redirect = jump_i && !stall_i;

  // ==========================================================================
  // fetch address
  // ==========================================================================

  // the target goes out in the redirect cycle itself
  assign inst_addr_o = redirect ? jump_target_i : pc_i;

  // ==========================================================================
  // instruction select
  // ==========================================================================
  assign word_idx = pc_i[ifu_pkg::WORD_IDX_LSB +: ifu_pkg::WORD_IDX_W];

  // word 0 sits in the low bits of the line
  assign inst_o = rdata_i[word_idx*ifu_pkg::INST_W +: ifu_pkg::INST_W];

  // ==========================================================================
  // commit and fault
  // ==========================================================================

  // a beat arriving with a redirect, or one already marked stale, is dropped
  assign commit = rd_done_i && !redirect && !discard_i;

  assign commit_o = commit;
  assign fault_o  = commit && (rresp_i != ifu_pkg::RESP_OKAY);

endmodule

// File: design/ifu_top.sv
// fetch stage top; one read in flight, 128-bit line per read, rst_n high holds reset
`timescale 1ns/1ns

module ifu_top (
  input  logic           clk,
  input  logic           rst_n,

  // redirect and stall from the pipeline
  input  logic           jump_i,
  input  ifu_pkg::addr_t jump_target_i,
  input  logic           stall_i,

  // read channel
  input  logic           arready_i,
  input  logic           rvalid_i,
  input  ifu_pkg::line_t rdata_i,
  input  ifu_pkg::resp_t rresp_i,
  output logic           arvalid_o,
  output logic           rready_o,

  // fetched instruction
  output ifu_pkg::addr_t inst_addr_o,
  output ifu_pkg::inst_t inst_o,
  output logic           commit_o,
  output logic           fault_o
);

  ifu_pkg::addr_t pc;
  logic           rd_done;
  logic           discard;

  ifu_pc_reg i_pc_reg (
    .clk           (clk),
    .rst_n         (rst_n),
    .jump_i        (jump_i),
    .jump_target_i (jump_target_i),
    .stall_i       (stall_i),
    .rd_done_i     (rd_done),
    .discard_i     (discard),
    .pc_o          (pc)
  );

  ifu_bus_fsm i_bus_fsm (
    .clk       (clk),
    .rst_n     (rst_n),
    .arready_i (arready_i),
    .rvalid_i  (rvalid_i),
    .stall_i   (stall_i),
    .jump_i    (jump_i),
    .arvalid_o (arvalid_o),
    .rready_o  (rready_o),
    .rd_done_o (rd_done),
    .discard_o (discard)
  );

  ifu_word_out i_word_out (
    .pc_i          (pc),
    .jump_i        (jump_i),
    .jump_target_i (jump_target_i),
    .stall_i       (stall_i),
    .rd_done_i     (rd_done),
    .discard_i     (discard),
    .rdata_i       (rdata_i),
    .rresp_i       (rresp_i),
    .inst_addr_o   (inst_addr_o),
    .inst_o        (inst_o),
    .commit_o      (commit_o),
    .fault_o       (fault_o)
  );

endmodule

// File: bench/ifu_tb.sv
// self-checking testbench; run from the project root, stimulus comes from bench/ifu_input.txt
`timescale 1ns/1ns

module ifu_tb;

  localparam int MAX_RECS         = 64;
  localparam int WAIT_LIMIT       = 200;
  localparam int CYCLES_PER_FETCH = 40;

  // ==========================================================================
  // DUT signals and slave model state
  // ==========================================================================
  logic           clk           = 1'b0;
  logic           rst_n         = 1'b1;
  logic           jump_i        = 1'b0;
  ifu_pkg::addr_t jump_target_i = '0;
  logic           stall_i       = 1'b0;
  logic           arready_i     = 1'b0;
  logic           rvalid_i      = 1'b0;
  ifu_pkg::line_t rdata_i       = '0;
  ifu_pkg::resp_t rresp_i       = '0;
  logic           arvalid_o;
  logic           rready_o;
  ifu_pkg::addr_t inst_addr_o;
  ifu_pkg::inst_t inst_o;
  logic           commit_o;
  logic           fault_o;

  // busy from address accept until the beat is taken
  logic           busy     = 1'b0;
  logic           beat_err = 1'b0;
  ifu_pkg::addr_t rd_addr  = '0;
  int             ar_wait  = 0;
  int             r_wait   = 0;
  int             ar_gap   = 0;
  int             r_gap    = 0;
  int             err_req  = 0;
  int             err_used = 0;
  integer         seed     = 65123;

  // expected stream restarts at base_addr after each redirect
  ifu_pkg::addr_t base_addr    = ifu_pkg::RESET_PC;
  int             base_count   = 0;
  int             commit_count = 0;
  int             faults_seen  = 0;

  logic [63:0]    recs [0:4*MAX_RECS-1];

  ifu_top i_dut (
    .clk           (clk),
    .rst_n         (rst_n),
    .jump_i        (jump_i),
    .jump_target_i (jump_target_i),
    .stall_i       (stall_i),
    .arready_i     (arready_i),
    .rvalid_i      (rvalid_i),
    .rdata_i       (rdata_i),
    .rresp_i       (rresp_i),
    .arvalid_o     (arvalid_o),
    .rready_o      (rready_o),
    .inst_addr_o   (inst_addr_o),
    .inst_o        (inst_o),
    .commit_o      (commit_o),
    .fault_o       (fault_o)
  );

  always #2 clk = ~clk;

  // ==========================================================================
  // helpers
  // ==========================================================================
  task automatic end_with_failure(input string why);
    $display("%s", why);
    $display("*** FAILED ***");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic compare_addr(input ifu_pkg::addr_t got, input ifu_pkg::addr_t exp,
                              input string what);
    if (got !== exp) begin
      end_with_failure($sformatf("** Error at %0t: %s is %h, expected %h", $time, what, got, exp));
    end
  endtask

  task automatic compare_inst(input ifu_pkg::inst_t got, input ifu_pkg::inst_t exp,
                              input string what);
    if (got !== exp) begin
      end_with_failure($sformatf("** Error at %0t: %s is %h, expected %h", $time, what, got, exp));
    end
  endtask

  task automatic compare_bit(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      end_with_failure($sformatf("** Error at %0t: %s is %b, expected %b", $time, what, got, exp));
    end
  endtask

  // memory image word at byte address a
  function automatic ifu_pkg::inst_t word_at(input ifu_pkg::addr_t a);
    return a[31:0] ^ 32'hA5A5_0000;
  endfunction

  // lowest address in the low bits of the line
  function automatic ifu_pkg::line_t line_for(input ifu_pkg::addr_t a);
    ifu_pkg::addr_t base;
    base = {a[63:4], 4'b0000};
    return {word_at(base + 64'd12), word_at(base + 64'd8), word_at(base + 64'd4), word_at(base)};
  endfunction

  // up to three extra cycles on top of the recorded delay
  function automatic int add_jitter(input int cycles);
    int r;
    r = $random(seed);
    return cycles + (r & 3);
  endfunction

  task automatic wait_slave(input logic want);
    int cycles;
    cycles = 0;
    do begin
      @(posedge clk);
      cycles++;
      if (cycles > WAIT_LIMIT) begin
        end_with_failure("timeout: the read channel never reached the expected state");
      end
    end while (busy !== want);
  endtask

  task automatic wait_commits(input int n);
    int goal;
    int cycles;
    goal = commit_count + n;
    cycles = 0;
    while (commit_count < goal) begin
      @(posedge clk);
      cycles++;
      if (cycles > n * CYCLES_PER_FETCH) begin
        end_with_failure($sformatf("timeout: %0d instructions still missing", goal - commit_count));
      end
    end
  endtask

  // ==========================================================================
  // read slave
  // ==========================================================================
  always @(posedge clk) begin
    if (rst_n) begin
      arready_i <= 1'b0;
      rvalid_i  <= 1'b0;
      busy      <= 1'b0;
      ar_wait   <= 0;
    end else if (!busy) begin
      if (arready_i && arvalid_o) begin
        arready_i <= 1'b0;
        busy      <= 1'b1;
        rd_addr   <= inst_addr_o;
        r_wait    <= add_jitter(r_gap);
      end else if (!arready_i) begin
        if (ar_wait == 0) begin
          arready_i <= 1'b1;
        end else begin
          ar_wait <= ar_wait - 1;
        end
      end
    end else if (rvalid_i) begin
      if (rready_o) begin
        rvalid_i <= 1'b0;
        busy     <= 1'b0;
        ar_wait  <= add_jitter(ar_gap);
      end
    end else if (r_wait == 0) begin
      rvalid_i <= 1'b1;
      rdata_i  <= line_for(rd_addr);
      // SLVERR on the next beat after an error record
      if (err_req != err_used) begin
        rresp_i  <= 2'b10;
        beat_err <= 1'b1;
        err_used <= err_used + 1;
      end else begin
        rresp_i  <= ifu_pkg::RESP_OKAY;
        beat_err <= 1'b0;
      end
    end else begin
      r_wait <= r_wait - 1;
    end
  end

  // ==========================================================================
  // commit monitor
  // ==========================================================================
  always @(negedge clk) begin : commit_monitor
    ifu_pkg::addr_t exp_a;
    if (!rst_n && commit_o === 1'b1) begin
      exp_a = base_addr + ifu_pkg::addr_t'(ifu_pkg::INST_BYTES)
                        * ifu_pkg::addr_t'(commit_count - base_count);
      compare_addr(inst_addr_o, exp_a, "inst_addr_o");
      compare_inst(inst_o, word_at(exp_a), "inst_o");
      compare_bit(fault_o, beat_err, "fault_o");
      if (fault_o) begin
        faults_seen = faults_seen + 1;
      end
      commit_count = commit_count + 1;
    end
  end

  // ==========================================================================
  // stimulus
  // ==========================================================================
  initial begin : stimulus
    logic [7:0]  pos;
    logic [63:0] arg;
    int          k;
    $readmemh("bench/ifu_input.txt", recs);

    for (k = 0; k < 2; k++) begin
      @(posedge clk);
      if (k == 1) begin
        rst_n <= 1'b0;
      end
      @(negedge clk);
      compare_bit(arvalid_o, 1'b0, "arvalid_o in reset");
      compare_bit(rready_o, 1'b0, "rready_o in reset");
      compare_bit(commit_o, 1'b0, "commit_o in reset");
    end
    @(posedge clk);
    @(negedge clk);
    compare_bit(arvalid_o, 1'b1, "arvalid_o after reset");

    pos = 8'd0;
    for (k = 0; k < MAX_RECS && recs[pos] !== 64'd0; k++) begin
      @(posedge clk);
      arg = recs[pos + 8'd1];
      ar_gap <= int'(recs[pos + 8'd2]);
      r_gap  <= int'(recs[pos + 8'd3]);
      case (recs[pos])
        64'd1: wait_commits(int'(arg));
        64'd2: begin
          // redirect while the read is out
          wait_slave(1'b0);
          wait_slave(1'b1);
          jump_i        <= 1'b1;
          jump_target_i <= arg;
          base_addr      = arg;
          base_count     = commit_count;
          @(posedge clk);
          jump_i <= 1'b0;
          wait_slave(1'b0);
          if (commit_count != base_count) begin
            end_with_failure("a commit came out of the discarded read");
          end
        end
        64'd3: begin
          wait_slave(1'b0);
          wait_slave(1'b1);
          stall_i <= 1'b1;
          repeat (int'(arg)) begin
            @(negedge clk);
            compare_bit(rready_o, 1'b0, "rready_o during stall");
            compare_bit(commit_o, 1'b0, "commit_o during stall");
            @(posedge clk);
          end
          stall_i <= 1'b0;
        end
        64'd4: err_req <= err_req + 1;
        default: end_with_failure($sformatf("record %0d of the stimulus file is unknown", k));
      endcase
      pos = pos + 8'd4;
    end

    @(posedge clk);
    if (faults_seen != err_req || commit_count == 0) begin
      end_with_failure($sformatf("%0d faults seen for %0d flagged beats", faults_seen, err_req));
    end else begin
      $display("*** PASSED ***");
      $finish;
    end
  end

endmodule

// File: bench/ifu_input.txt
// columns: op arg ar_delay r_delay, all hex; the delays hold from that record on
// op 1 runs arg instructions, 2 jumps to arg, 3 stalls arg cycles, 4 flags the next beat, 0 ends

// sequential fetch from the reset pc, every word slot of two lines
1 0000000000000008 0 0
// slower slave, same stream
1 0000000000000005 3 2
// redirect into the middle of a line while a read is out
2 0000000080001008 0 2
1 0000000000000006 0 0
// stall with the beat already waiting
3 0000000000000005 0 0
1 0000000000000003 1 0
// error response on one beat only
4 0000000000000000 0 1
1 0000000000000004 0 1
// target above 4 GiB, last word of a line
2 000000104000200c 2 4
1 0000000000000005 1 1
// long stall while the slave is slow
3 0000000000000008 0 4
1 0000000000000002 0 4
// second error, then back near the reset pc
4 0000000000000000 2 0
1 0000000000000003 2 0
2 0000000080000004 1 3
3 0000000000000002 0 0
1 0000000000000007 0 0
// quick redirect with no slave delay
2 0000000080004000 0 0
1 0000000000000006 5 5
0 0000000000000000 0 0

// File: ifu_top.f
design/ifu_pkg.sv
design/ifu_pc_reg.sv
design/ifu_bus_fsm.sv
design/ifu_word_out.sv
design/ifu_top.sv
bench/ifu_tb.sv

// File: Makefile
# Verilator build and run of the fetch stage testbench

VERILATOR ?= verilator
TB_TOP    ?= ifu_tb
FILELIST  ?= ifu_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
FAIL_MSG  ?= *** FAILED ***
PASS_MSG  ?= *** PASSED ***

SOURCES := $(shell cat $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TB_TOP)

.PHONY: all build run lint clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TB_TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# the log decides the result, the exit code of the model is not used
run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -qF '$(FAIL_MSG)' $(LOG); then \
	  echo "simulation reported a failure, see $(LOG)"; \
	  exit 1; \
	fi
	@if ! grep -qF '$(PASS_MSG)' $(LOG); then \
	  echo "simulation ended without a result, see $(LOG)"; \
	  exit 1; \
	fi

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TB_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
